//--- Makefile
VERILATOR ?= verilator
TOP       ?= victim_cache_tb
FILELIST  ?= victim_cache.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- src/victim_cache.sv
`default_nettype none

`include "victim_cache_defs.svh"

module victim_cache import victim_cache_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       insert_i,
    input  vc_insert_t insert_req_i,
    input  logic       lookup_i,
    input  vc_lookup_t lookup_req_i,
    output logic       resp_valid_o,
    output vc_resp_t   resp_o
);

    vc_index_t                      index;
    vc_tag_t                        tag;
    vc_tag_entry_t [`VC_WAYS-1:0]   tag_set;
    vc_line_t [`VC_WAYS-1:0]        line_set;
    logic                           hit;
    logic                           has_free;
    vc_way_t                        hit_way;
    vc_way_t                        free_way;
    vc_way_t                        lru_way;
    vc_way_t                        write_way;
    logic                           lookup_hit;
    logic                           tag_we;
    vc_way_t                        tag_way;
    vc_tag_entry_t                  tag_wdata;
    logic                           resp_valid_q;
    vc_resp_t                       resp_q;

    // insert owns the set port when it strobes
    assign index = insert_i ? insert_req_i.index : lookup_req_i.index;
    assign tag   = insert_i ? insert_req_i.tag : lookup_req_i.tag;

    // same tag first, then a hole, then the plru victim
    // a dropped victim needs no writeback
    assign write_way = hit ? hit_way : (has_free ? free_way : lru_way);

    // exclusive cache, a hit hands the line back to the l1
    assign lookup_hit = lookup_i & hit;

    // tag store writes on insert and clears valid on a lookup hit
    assign tag_we          = insert_i | lookup_hit;
    assign tag_way         = insert_i ? write_way : hit_way;
    assign tag_wdata.valid = insert_i;
    assign tag_wdata.tag   = tag;

    victim_way_store #(
        .entry_t (vc_tag_entry_t)
    ) u_tag_store (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .we_i    (tag_we),
        .index_i (index),
        .way_i   (tag_way),
        .wdata_i (tag_wdata),
        .set_o   (tag_set)
    );

    // line payload, only inserts write it
    victim_way_store #(
        .entry_t (vc_line_t)
    ) u_line_store (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .we_i    (insert_i),
        .index_i (index),
        .way_i   (write_way),
        .wdata_i (insert_req_i.line),
        .set_o   (line_set)
    );

    victim_lookup u_lookup (
        .clk_i      (clk_i),
        .set_i      (tag_set),
        .tag_i      (tag),
        .hit_o      (hit),
        .hit_way_o  (hit_way),
        .has_free_o (has_free),
        .free_way_o (free_way)
    );

    // tree follows the way each insert lands in
    victim_plru u_plru (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .touch_i   (insert_i),
        .index_i   (index),
        .way_i     (write_way),
        .lru_way_o (lru_way)
    );

    // one-cycle response pulse after each lookup
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= lookup_i;
        end
    end

    // payload captured with the lookup, zero line on a miss
    always_ff @(posedge clk_i) begin
        if (lookup_i) begin
            resp_q.hit  <= hit;
            resp_q.line <= hit ? line_set[hit_way] : '0;
        end
    end

    assign resp_valid_o = resp_valid_q;
    assign resp_o       = resp_q;

    // one shared set port, so the requester must serialize
    a_no_insert_lookup: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !(insert_i && lookup_i)
    );

endmodule

`default_nettype wire

//--- src/victim_cache_defs.svh
`ifndef VICTIM_CACHE_DEFS_SVH
`define VICTIM_CACHE_DEFS_SVH

// number of sets in the victim buffer
`define VC_SETS 16
// set index width, log2 of VC_SETS
`define VC_INDEX_W 4

// ways per set, fixed by the 3-level plru tree
`define VC_WAYS 8
`define VC_WAY_W 3

// tag kept per line
`define VC_TAG_W 22

// instruction line payload in bits
`define VC_LINE_W 128

`endif

//--- src/victim_cache_pkg.sv
`default_nettype none

`include "victim_cache_defs.svh"

package victim_cache_pkg;

    typedef logic [`VC_INDEX_W-1:0] vc_index_t;
    typedef logic [`VC_WAY_W-1:0]   vc_way_t;
    typedef logic [`VC_TAG_W-1:0]   vc_tag_t;
    typedef logic [`VC_LINE_W-1:0]  vc_line_t;

    // one tag store entry, valid in the msb
    typedef struct packed {
        logic    valid;
        vc_tag_t tag;
    } vc_tag_entry_t;

    // line evicted by the l1
    typedef struct packed {
        vc_index_t index;
        vc_tag_t   tag;
        vc_line_t  line;
    } vc_insert_t;

    // l1 miss probe
    typedef struct packed {
        vc_index_t index;
        vc_tag_t   tag;
    } vc_lookup_t;

    // line is zero on a miss
    typedef struct packed {
        logic     hit;
        vc_line_t line;
    } vc_resp_t;

endpackage

`default_nettype wire

//--- src/victim_lookup.sv
`default_nettype none

`include "victim_cache_defs.svh"

module victim_lookup import victim_cache_pkg::*; (
    // only for the assertion below
    input  logic                           clk_i,
    input  vc_tag_entry_t [`VC_WAYS-1:0]   set_i,
    input  vc_tag_t                        tag_i,
    output logic                           hit_o,
    output vc_way_t                        hit_way_o,
    output logic                           has_free_o,
    output vc_way_t                        free_way_o
);

    logic [`VC_WAYS-1:0] valid;
    logic [`VC_WAYS-1:0] match;

    // per-way compare, invalid entries never match
    always_comb begin
        for (int w = 0; w < `VC_WAYS; w++) begin
            valid[w] = set_i[w].valid;
            match[w] = set_i[w].valid && (set_i[w].tag == tag_i);
        end
    end

    // scan from the top so the lowest way wins
    always_comb begin
        hit_way_o  = '0;
        free_way_o = '0;
        for (int w = `VC_WAYS - 1; w >= 0; w--) begin
            if (match[w]) begin
                hit_way_o = vc_way_t'(w);
            end
            if (!valid[w]) begin
                free_way_o = vc_way_t'(w);
            end
        end
    end

    assign hit_o      = |match;
    assign has_free_o = ~&valid;

    // the top rewrites a present tag in place, so a tag never sits in two ways
    a_match_onehot0: assert property (
        @(posedge clk_i)
        !$isunknown(match) |-> $onehot0(match)
    );

endmodule

`default_nettype wire

//--- src/victim_plru.sv
`default_nettype none

`include "victim_cache_defs.svh"

module victim_plru import victim_cache_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      touch_i,
    input  vc_index_t index_i,
    input  vc_way_t   way_i,
    output vc_way_t   lru_way_o
);

    // node n has children 2n+1 and 2n+2
    // touch[n] enters node n and touch[0] comes from the port
    logic [6:0] touch;
    logic [6:0] node_bit;
    vc_way_t    lru_way;

    assign touch[0] = touch_i;

    for (genvar n = 0; n < 7; n++) begin : g_node
        // tree level of node n with the root at 0
        localparam int LVL = $clog2(n + 2) - 1;

        // level 0 steers on way bit 2 and the leaves on bit 0
        if (LVL < 2) begin : g_inner
            victim_plru_node u_node (
                .clk_i         (clk_i),
                .rst_ni        (rst_ni),
                .touch_i       (touch[n]),
                .index_i       (index_i),
                .dir_i         (way_i[2 - LVL]),
                .touch_left_o  (touch[2 * n + 1]),
                .touch_right_o (touch[2 * n + 2]),
                .bit_o         (node_bit[n])
            );
        end else begin : g_leaf
            // the path ends at a leaf so its touch outputs stay open
            victim_plru_node u_node (
                .clk_i         (clk_i),
                .rst_ni        (rst_ni),
                .touch_i       (touch[n]),
                .index_i       (index_i),
                .dir_i         (way_i[0]),
                .touch_left_o  (),
                .touch_right_o (),
                .bit_o         (node_bit[n])
            );
        end
    end

    // walk away from the recently used side at every level
    always_comb begin
        lru_way[2] = ~node_bit[0];
        // root pointed right means the right subtree L2
        if (lru_way[2]) begin
            lru_way[1] = ~node_bit[2];
        end else begin
            lru_way[1] = ~node_bit[1];
        end
        // pick the leaf node below the chosen L1 or L2
        case (lru_way[2:1])
            2'b00:   lru_way[0] = ~node_bit[3];
            2'b01:   lru_way[0] = ~node_bit[4];
            2'b10:   lru_way[0] = ~node_bit[5];
            default: lru_way[0] = ~node_bit[6];
        endcase
    end

    assign lru_way_o = lru_way;

    // a touch with an unknown way would corrupt the set's tree
    a_touch_way_known: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        touch_i |-> !$isunknown(way_i)
    );

endmodule

`default_nettype wire

//--- src/victim_plru_node.sv
`default_nettype none

`include "victim_cache_defs.svh"

module victim_plru_node import victim_cache_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      touch_i,
    input  vc_index_t index_i,
    input  logic      dir_i,
    output logic      touch_left_o,
    output logic      touch_right_o,
    output logic      bit_o
);

    // one steering bit per set
    logic [`VC_SETS-1:0] bits_q;

    // bit records which side was used last, 0 is left
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            bits_q <= '0;
        end else if (touch_i) begin
            bits_q[index_i] <= dir_i;
        end
    end

    // touch goes on to the child on the used side
    assign touch_left_o  = touch_i & ~dir_i;
    assign touch_right_o = touch_i & dir_i;

    // stored bit of the addressed set for the decode
    assign bit_o = bits_q[index_i];

endmodule

`default_nettype wire

//--- src/victim_way_store.sv
`default_nettype none

`include "victim_cache_defs.svh"

module victim_way_store import victim_cache_pkg::*; #(
    parameter type entry_t = vc_line_t
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      we_i,
    input  vc_index_t                 index_i,
    input  vc_way_t                   way_i,
    input  entry_t                    wdata_i,
    output entry_t [`VC_WAYS-1:0]     set_o
);

    // all ways of one set side by side
    entry_t [`VC_WAYS-1:0] mem_q [`VC_SETS];

    // single write port at one set and way
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            for (int s = 0; s < `VC_SETS; s++) begin
                mem_q[s] <= '0;
            end
        end else if (we_i) begin
            mem_q[index_i][way_i] <= wdata_i;
        end
    end

    // whole set read out without a clock
    // the lookup compares all ways at once
    assign set_o = mem_q[index_i];

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_no
);
    timeunit 1ns;
    timeprecision 1ps;

    // free running clock, low at time 0
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // reset released on a rising edge, like a synchronous source
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

`default_nettype wire

//--- tb/victim_cache_tb.sv
`default_nettype none

`include "victim_cache_defs.svh"

module victim_cache_tb import victim_cache_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 100;
    localparam int RAND_N     = 300;
    localparam logic [1:0] OP_IDLE = 2'd0;
    localparam logic [1:0] OP_INS  = 2'd1;
    localparam logic [1:0] OP_LKP  = 2'd2;

    // one operation per row, use_model rows take the expectation from the model
    typedef struct packed {
        logic [1:0] op;
        logic       use_model;
        vc_index_t  index;
        vc_tag_t    tag;
        vc_line_t   line;
        logic       exp_hit;
        vc_line_t   exp_line;
    } stim_row_t;

    logic       clk;
    logic       rst_n;
    logic       insert;
    vc_insert_t insert_req;
    logic       lookup;
    vc_lookup_t lookup_req;
    logic       resp_valid;
    vc_resp_t   resp;

    stim_row_t   rows[$];
    logic [15:0] lfsr = 16'd41;
    bit          table_ready = 1'b0;

    // reference model of both stores and the plru bits
    bit       m_valid [`VC_SETS][`VC_WAYS];
    vc_tag_t  m_tag [`VC_SETS][`VC_WAYS];
    vc_line_t m_line [`VC_SETS][`VC_WAYS];
    bit       m_tree [`VC_SETS][7];

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(2)) u_clk (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    victim_cache uut (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .insert_i     (insert),
        .insert_req_i (insert_req),
        .lookup_i     (lookup),
        .lookup_req_i (lookup_req),
        .resp_valid_o (resp_valid),
        .resp_o       (resp)
    );

    // galois lfsr, one step per bit taken
    function automatic int unsigned draw(int n);
        int unsigned r = 0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic vc_line_t mk_line(int n);
        return {4{32'hc0de_0000 | 32'(n)}};
    endfunction

    task automatic add_row(logic [1:0] op, int idx, int tag, int n, logic hit);
        stim_row_t r;
        r.op        = op;
        r.use_model = 1'b0;
        r.index     = vc_index_t'(idx);
        r.tag       = vc_tag_t'(tag);
        r.line      = mk_line(n);
        r.exp_hit   = hit;
        r.exp_line  = hit ? mk_line(n) : '0;
        rows.push_back(r);
    endtask

    function automatic int find_way(int s, vc_tag_t tag);
        for (int w = 0; w < `VC_WAYS; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == tag) begin
                return w;
            end
        end
        return -1;
    endfunction

    // walk to the side opposite each stored bit
    function automatic int tree_victim(int s);
        int w2;
        int w1;
        int w0;
        w2 = m_tree[s][0] ? 0 : 1;
        w1 = m_tree[s][1 + w2] ? 0 : 1;
        w0 = m_tree[s][3 + 2 * w2 + w1] ? 0 : 1;
        return 4 * w2 + 2 * w1 + w0;
    endfunction

    // root gets way bit 2, then one node per level down the used side
    task automatic touch(int s, int w);
        int b2;
        int b1;
        b2 = (w >> 2) & 1;
        b1 = (w >> 1) & 1;
        m_tree[s][0]               = bit'(b2);
        m_tree[s][1 + b2]          = bit'(b1);
        m_tree[s][3 + 2 * b2 + b1] = bit'(w & 1);
    endtask

    // same tag, else lowest free way, else the tree victim
    task automatic model_insert(int s, vc_tag_t tag, vc_line_t line);
        int w;
        w = find_way(s, tag);
        for (int f = 0; f < `VC_WAYS; f++) begin
            if (w < 0 && !m_valid[s][f]) w = f;
        end
        if (w < 0) w = tree_victim(s);
        m_valid[s][w] = 1'b1;
        m_tag[s][w]   = tag;
        m_line[s][w]  = line;
        touch(s, w);
    endtask

    task automatic check(string name, logic [`VC_LINE_W-1:0] got, logic [`VC_LINE_W-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic build_table();
        // empty cache after reset, then an idle cycle
        add_row(OP_LKP, 3, 'h5, 0, 1'b0);
        add_row(OP_IDLE, 0, 0, 0, 1'b0);
        add_row(OP_LKP, 15, 'h3fffff, 0, 1'b0);
        // exclusive hit hands the line out once
        add_row(OP_INS, 1, 'h100, 1, 1'b0);
        add_row(OP_LKP, 1, 'h100, 1, 1'b1);
        add_row(OP_LKP, 1, 'h100, 0, 1'b0);
        // touches 0..7 leave the tree at way 0
        for (int w = 0; w < 9; w++) add_row(OP_INS, 2, 'h200 + w, 16 + w, 1'b0);
        add_row(OP_LKP, 2, 'h200, 0, 1'b0);
        for (int w = 1; w < 9; w++) add_row(OP_LKP, 2, 'h200 + w, 16 + w, 1'b1);
        // rewrite in place, no stale copy left behind
        add_row(OP_INS, 3, 'h300, 32, 1'b0);
        add_row(OP_INS, 3, 'h301, 33, 1'b0);
        add_row(OP_INS, 3, 'h300, 34, 1'b0);
        add_row(OP_LKP, 3, 'h300, 34, 1'b1);
        add_row(OP_LKP, 3, 'h301, 33, 1'b1);
        add_row(OP_LKP, 3, 'h300, 0, 1'b0);
        // set 5 insert in between must not move set 4's victim
        for (int w = 0; w < 8; w++) add_row(OP_INS, 4, 'h400 + w, 48 + w, 1'b0);
        add_row(OP_INS, 5, 'h500, 64, 1'b0);
        add_row(OP_INS, 4, 'h408, 56, 1'b0);
        add_row(OP_LKP, 5, 'h500, 64, 1'b1);
        add_row(OP_LKP, 4, 'h400, 0, 1'b0);
        add_row(OP_LKP, 4, 'h401, 49, 1'b1);
        add_row(OP_LKP, 4, 'h408, 56, 1'b1);
    endtask

    // small index and tag ranges so sets fill up and evict
    task automatic build_random();
        stim_row_t  r;
        logic [1:0] sel;
        for (int k = 0; k < RAND_N; k++) begin
            sel         = 2'(draw(2));
            r.op        = (sel == 2'd0) ? OP_IDLE : ((sel == 2'd2) ? OP_LKP : OP_INS);
            r.use_model = 1'b1;
            r.index     = vc_index_t'(draw(2));
            r.tag       = vc_tag_t'(draw(4));
            r.line      = {8{16'(draw(16))}};
            r.exp_hit   = 1'b0;
            r.exp_line  = '0;
            rows.push_back(r);
        end
    endtask

    // row i is driven at one edge, its response checked after the next
    task automatic apply_rows();
        stim_row_t r;
        logic      exp_valid;
        logic      exp_hit;
        vc_line_t  exp_line;
        logic      nxt_valid;
        logic      nxt_hit;
        vc_line_t  nxt_line;
        int        w;
        exp_valid = 1'b0;
        exp_hit   = 1'b0;
        exp_line  = '0;
        for (int i = 0; i <= rows.size(); i++) begin
            @(posedge clk);
            r = (i < rows.size()) ? rows[i] : '0;
            insert     <= (r.op == OP_INS);
            insert_req <= {r.index, r.tag, r.line};
            lookup     <= (r.op == OP_LKP);
            lookup_req <= {r.index, r.tag};
            nxt_valid = (r.op == OP_LKP);
            nxt_hit   = r.exp_hit;
            nxt_line  = r.exp_line;
            if (r.op == OP_INS) model_insert(int'(r.index), r.tag, r.line);
            if (r.op == OP_LKP) begin
                w = find_way(int'(r.index), r.tag);
                if (r.use_model) begin
                    nxt_hit  = (w >= 0);
                    nxt_line = (w >= 0) ? m_line[r.index][w] : '0;
                end
                if (w >= 0) m_valid[r.index][w] = 1'b0;
            end
            @(negedge clk);
            if (i > 0) begin
                check("resp_valid_o", 128'(resp_valid), 128'(exp_valid));
                if (exp_valid) begin
                    check("resp_o.hit", 128'(resp.hit), 128'(exp_hit));
                    check("resp_o.line", resp.line, exp_line);
                end
            end
            exp_valid = nxt_valid;
            exp_hit   = nxt_hit;
            exp_line  = nxt_line;
        end
    endtask

    initial begin
        insert     = 1'b0;
        insert_req = '0;
        lookup     = 1'b0;
        lookup_req = '0;
        build_table();
        build_random();
        table_ready = 1'b1;
        wait (rst_n);
        @(negedge clk);
        check("resp_valid_o", 128'(resp_valid), 128'(1'b0));
        apply_rows();
        $display(">>> PASS");
        $finish;
    end

    // all rows plus reset and drain, with some slack
    initial begin
        wait (table_ready);
        #((rows.size() + 20) * CLK_PERIOD);
        $display(">>> FAIL");
        $fatal(1, "timeout: run did not end within %0d clock cycles", rows.size() + 20);
    end

endmodule

`default_nettype wire

//--- victim_cache.f
+incdir+src
src/victim_cache_pkg.sv
src/victim_plru_node.sv
src/victim_plru.sv
src/victim_way_store.sv
src/victim_lookup.sv
src/victim_cache.sv
tb/tb_clock_gen.sv
tb/victim_cache_tb.sv
